//--- flist.f
rtl/tag_lookup_pkg.sv
rtl/ram_1r1w.sv
rtl/tag_table.sv
rtl/scan_counter.sv
rtl/lookup_fsm.sv
rtl/pu_tag_result_mem.sv
rtl/tag_lookup_top.sv
verification/tag_lookup_checker.sv
verification/tb_tag_lookup.sv

//--- rtl/lookup_fsm.sv
// ********************
// lookup sequencer
// ********************

module lookup_fsm (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  tag_lookup_pkg::lookup_req_t                lookup_req,
	input  tag_lookup_pkg::tag_entry_t                 entry,
	input  logic                                       last,
	input  logic [tag_lookup_pkg::HIT_COUNT_NBITS-1:0] hit_count,
	output logic                                       clear,
	output logic                                       step,
	output logic                                       hit,
	output logic                                       lookup_ready,
	output tag_lookup_pkg::tag_result_t                tag_result,
	output tag_lookup_pkg::tag_status_t                tag_status
);

	tag_lookup_pkg::lookup_state_t state_q;
	tag_lookup_pkg::lookup_state_t state_nxt;

	logic                                     accept;
	logic                                     store;
	logic                                     overflow;
	logic [tag_lookup_pkg::RESULT_NUM_NBITS-1:0] stored;
	logic [tag_lookup_pkg::PU_ID_NBITS-1:0]   pid_q;
	logic [tag_lookup_pkg::TAG_KEY_NBITS-1:0] key_q;

	// ********************
	// state machine
	// ********************

	assign accept = lookup_req.valid & lookup_ready;
	assign clear  = accept;
	assign step   = (state_q == tag_lookup_pkg::SCAN);
	assign hit    = step & entry.valid & (entry.key == key_q);

	always_comb begin
		state_nxt = state_q;
		case (state_q)
			tag_lookup_pkg::IDLE: begin
				if (accept) begin
					state_nxt = tag_lookup_pkg::SCAN;
				end
			end
			tag_lookup_pkg::SCAN: begin
				if (last) begin
					state_nxt = tag_lookup_pkg::STATUS;
				end
			end
			default: begin
				state_nxt = tag_lookup_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= tag_lookup_pkg::IDLE;
		end else begin
			state_q <= state_nxt;
		end
	end

	// ready comes back once the status word has gone out.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lookup_ready <= 1'b1;
		end else if (accept) begin
			lookup_ready <= 1'b0;
		end else if (tag_status.valid) begin
			lookup_ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pid_q <= lookup_req.pid;
			key_q <= lookup_req.key;
		end
	end

	// ********************
	// result and status strobes
	// ********************

	// only the first six hits are written, later ones just count.
	assign store    = hit & (hit_count < tag_lookup_pkg::MAX_RESULTS);
	assign overflow = (hit_count > tag_lookup_pkg::MAX_RESULTS);
	assign stored   = overflow ? tag_lookup_pkg::RESULT_NUM_NBITS'(tag_lookup_pkg::MAX_RESULTS)
		: hit_count[tag_lookup_pkg::RESULT_NUM_NBITS-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tag_result <= '0;
			tag_status <= '0;
		end else begin
			tag_result.valid  <= store;
			tag_result.pid    <= pid_q;
			tag_result.num    <= hit_count[tag_lookup_pkg::RESULT_NUM_NBITS-1:0];
			tag_result.rci    <= entry.rci;
			tag_status.valid  <= (state_q == tag_lookup_pkg::STATUS);
			tag_status.pid    <= pid_q;
			tag_status.status <= {overflow, stored};
		end
	end

endmodule

//--- rtl/pu_tag_result_mem.sv
// ********************
// per PU tag result memory
// ********************

module pu_tag_result_mem (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  tag_lookup_pkg::tag_result_t              tag_result,
	input  tag_lookup_pkg::tag_status_t              tag_status,
	input  logic [tag_lookup_pkg::NUM_OF_PU-1:0]     io_req,
	input  tag_lookup_pkg::io_type [tag_lookup_pkg::NUM_OF_PU-1:0] io_cmd,
	output logic [tag_lookup_pkg::NUM_OF_PU-1:0]     io_ack,
	output logic [tag_lookup_pkg::NUM_OF_PU-1:0][tag_lookup_pkg::PU_WIDTH_NBITS-1:0] io_ack_data
);

	// each io word is split into two half words of result index width.
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] req_d1;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] req_d2;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] rd_d2;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] region_hit;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] region_rd;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] wr_l;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] wr_h;

	tag_lookup_pkg::io_type [tag_lookup_pkg::NUM_OF_PU-1:0] cmd_d1;

	logic [tag_lookup_pkg::TAG_RESULT_DEPTH_NBITS-1:0] waddr;
	logic [tag_lookup_pkg::RCI_NBITS-1:0]              wdata_l;
	logic [tag_lookup_pkg::RCI_NBITS-1:0]              wdata_h;

	logic [tag_lookup_pkg::NUM_OF_PU-1:0][tag_lookup_pkg::TAG_RESULT_DEPTH_NBITS-1:0] raddr;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0][tag_lookup_pkg::RCI_NBITS-1:0] rdata_l;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0][tag_lookup_pkg::RCI_NBITS-1:0] rdata_h;

	// ********************
	// write steering
	// ********************

	// status owns word 0, result n lands in word n/2+1.
	// the sequencer never issues a result and a status in the same cycle.
	always_comb begin
		if (tag_status.valid) begin
			waddr   = '0;
			wdata_l = {{(tag_lookup_pkg::RCI_NBITS - tag_lookup_pkg::STATUS_NBITS){1'b0}},
				tag_status.status};
			wdata_h = '0;
		end else begin
			waddr   = tag_result.num[2:1] + 1'b1;
			wdata_l = tag_result.rci;
			wdata_h = tag_result.rci;
		end
	end

	// ********************
	// io request pipeline
	// ********************

	always_ff @(posedge clk) begin
		cmd_d1 <= io_cmd;
	end

	// stage one registers the command, stage two qualifies the region,
	// and the third edge drives the acknowledge.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_d1      <= '0;
			req_d2      <= '0;
			rd_d2       <= '0;
			io_ack      <= '0;
			io_ack_data <= '0;
		end else begin
			req_d1 <= io_req;
			req_d2 <= req_d1 & region_hit;
			rd_d2  <= req_d1 & region_rd;
			io_ack <= req_d2;
			for (int i = 0; i < tag_lookup_pkg::NUM_OF_PU; i++) begin
				io_ack_data[i] <= rd_d2[i] ? {rdata_h[i], rdata_l[i]} : '0;
			end
		end
	end

	// ********************
	// per PU lanes
	// ********************

	for (genvar gi = 0; gi < tag_lookup_pkg::NUM_OF_PU; gi++) begin : g_lane

		assign region_hit[gi] = (cmd_d1[gi].addr[tag_lookup_pkg::IO_REGION_MSB:
			tag_lookup_pkg::IO_REGION_LSB] == tag_lookup_pkg::PU_TAG_LOOKUP_RESULT);
		assign region_rd[gi]  = region_hit[gi] & ~cmd_d1[gi].wr;
		assign raddr[gi]      = cmd_d1[gi].addr[tag_lookup_pkg::TAG_RESULT_DEPTH_NBITS-1:0];

		// odd result numbers use the low half, even ones the high half.
		assign wr_l[gi] = (tag_result.valid & (tag_result.pid == gi) & tag_result.num[0])
			| (tag_status.valid & (tag_status.pid == gi));
		assign wr_h[gi] = (tag_result.valid & (tag_result.pid == gi) & ~tag_result.num[0])
			| (tag_status.valid & (tag_status.pid == gi));

		ram_1r1w #(
			.WIDTH       (tag_lookup_pkg::RCI_NBITS),
			.DEPTH_NBITS (tag_lookup_pkg::TAG_RESULT_DEPTH_NBITS)
		) u_ram_h (
			.clk   (clk),
			.wr    (wr_h[gi]),
			.waddr (waddr),
			.raddr (raddr[gi]),
			.din   (wdata_h),
			.dout  (rdata_h[gi])
		);

		ram_1r1w #(
			.WIDTH       (tag_lookup_pkg::RCI_NBITS),
			.DEPTH_NBITS (tag_lookup_pkg::TAG_RESULT_DEPTH_NBITS)
		) u_ram_l (
			.clk   (clk),
			.wr    (wr_l[gi]),
			.waddr (waddr),
			.raddr (raddr[gi]),
			.din   (wdata_l),
			.dout  (rdata_l[gi])
		);

	end

endmodule

//--- rtl/ram_1r1w.sv
// ********************
// one read one write RAM
// ********************

module ram_1r1w #(
	parameter int WIDTH       = 16,
	parameter int DEPTH_NBITS = 2
) (
	input  logic                   clk,
	input  logic                   wr,
	input  logic [DEPTH_NBITS-1:0] waddr,
	input  logic [DEPTH_NBITS-1:0] raddr,
	input  logic [WIDTH-1:0]       din,
	output logic [WIDTH-1:0]       dout
);

	logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
	end

	// read data appears one cycle after the address.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

//--- rtl/scan_counter.sv
// ********************
// scan index and hit counter
// ********************

module scan_counter (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic                                           clear,
	input  logic                                           step,
	input  logic                                           hit,
	output logic [tag_lookup_pkg::TAG_TABLE_IDX_NBITS-1:0] idx,
	output logic                                           last,
	output logic [tag_lookup_pkg::HIT_COUNT_NBITS-1:0]     hit_count
);

	// the index wraps back to zero after the last entry.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (clear) begin
			idx <= '0;
		end else if (step) begin
			idx <= idx + 1'b1;
		end
	end

	// the hit count saturates so it cannot roll over to a small value.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hit_count <= '0;
		end else if (clear) begin
			hit_count <= '0;
		end else if (step && hit && (hit_count != '1)) begin
			hit_count <= hit_count + 1'b1;
		end
	end

	assign last = (idx == tag_lookup_pkg::TAG_TABLE_IDX_NBITS'(
		tag_lookup_pkg::TAG_TABLE_ENTRIES - 1));

endmodule

//--- rtl/tag_lookup_pkg.sv
// ********************
// tag lookup types and constants
// ********************

package tag_lookup_pkg;

	// ********************
	// sizes
	// ********************

	localparam int NUM_OF_PU              = 4;
	localparam int PU_ID_NBITS            = 2;
	localparam int PU_WIDTH_NBITS         = 32;
	localparam int RCI_NBITS              = 16;
	localparam int TAG_KEY_NBITS          = 12;
	localparam int TAG_TABLE_ENTRIES      = 8;
	localparam int TAG_TABLE_IDX_NBITS    = 3;
	localparam int TAG_RESULT_DEPTH_NBITS = 2;
	localparam int MAX_RESULTS            = 6;
	localparam int RESULT_NUM_NBITS       = 3;
	localparam int HIT_COUNT_NBITS        = 4;
	localparam int STATUS_NBITS           = 4;

	// io address decode. the region field selects the tag result block.
	localparam int IO_ADDR_NBITS             = 8;
	localparam int IO_REGION_MSB             = 7;
	localparam int IO_REGION_LSB             = 4;
	localparam logic [3:0] PU_TAG_LOOKUP_RESULT = 4'h3;

	// ********************
	// types
	// ********************

	typedef enum logic [1:0] {
		IDLE,
		SCAN,
		STATUS
	} lookup_state_t;

	typedef struct packed {
		logic                     valid;
		logic [TAG_KEY_NBITS-1:0] key;
		logic [RCI_NBITS-1:0]     rci;
	} tag_entry_t;

	typedef struct packed {
		logic                           valid;
		logic [TAG_TABLE_IDX_NBITS-1:0] idx;
		tag_entry_t                     entry;
	} tag_cfg_t;

	typedef struct packed {
		logic                     valid;
		logic [PU_ID_NBITS-1:0]   pid;
		logic [TAG_KEY_NBITS-1:0] key;
	} lookup_req_t;

	typedef struct packed {
		logic                        valid;
		logic [PU_ID_NBITS-1:0]      pid;
		logic [RESULT_NUM_NBITS-1:0] num;
		logic [RCI_NBITS-1:0]        rci;
	} tag_result_t;

	// status bit 3 flags overflow, bits 2 to 0 hold the stored result count.
	typedef struct packed {
		logic                    valid;
		logic [PU_ID_NBITS-1:0]  pid;
		logic [STATUS_NBITS-1:0] status;
	} tag_status_t;

	typedef struct packed {
		logic                      wr;
		logic [IO_ADDR_NBITS-1:0]  addr;
		logic [PU_WIDTH_NBITS-1:0] data;
	} io_type;

endpackage

//--- rtl/tag_lookup_top.sv
// ********************
// tag lookup subsystem
// ********************

module tag_lookup_top (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  tag_lookup_pkg::tag_cfg_t                 tag_cfg,
	input  tag_lookup_pkg::lookup_req_t              lookup_req,
	output logic                                     lookup_ready,
	input  logic [tag_lookup_pkg::NUM_OF_PU-1:0]     io_req,
	input  tag_lookup_pkg::io_type [tag_lookup_pkg::NUM_OF_PU-1:0] io_cmd,
	output logic [tag_lookup_pkg::NUM_OF_PU-1:0]     io_ack,
	output logic [tag_lookup_pkg::NUM_OF_PU-1:0][tag_lookup_pkg::PU_WIDTH_NBITS-1:0] io_ack_data
);

	tag_lookup_pkg::tag_entry_t                     entry;
	tag_lookup_pkg::tag_result_t                    tag_result;
	tag_lookup_pkg::tag_status_t                    tag_status;
	logic [tag_lookup_pkg::TAG_TABLE_IDX_NBITS-1:0] idx;
	logic [tag_lookup_pkg::HIT_COUNT_NBITS-1:0]     hit_count;
	logic                                           last;
	logic                                           clear;
	logic                                           step;
	logic                                           hit;

	tag_table u_tag_table (
		.clk     (clk),
		.rst_n   (rst_n),
		.tag_cfg (tag_cfg),
		.idx     (idx),
		.entry   (entry)
	);

	scan_counter u_scan_counter (
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.step      (step),
		.hit       (hit),
		.idx       (idx),
		.last      (last),
		.hit_count (hit_count)
	);

	lookup_fsm u_lookup_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.lookup_req   (lookup_req),
		.entry        (entry),
		.last         (last),
		.hit_count    (hit_count),
		.clear        (clear),
		.step         (step),
		.hit          (hit),
		.lookup_ready (lookup_ready),
		.tag_result   (tag_result),
		.tag_status   (tag_status)
	);

	pu_tag_result_mem u_pu_tag_result_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.tag_result  (tag_result),
		.tag_status  (tag_status),
		.io_req      (io_req),
		.io_cmd      (io_cmd),
		.io_ack      (io_ack),
		.io_ack_data (io_ack_data)
	);

endmodule

//--- rtl/tag_table.sv
// ********************
// programmable tag table
// ********************

module tag_table (
	input  logic                                          clk,
	input  logic                                          rst_n,
	input  tag_lookup_pkg::tag_cfg_t                      tag_cfg,
	input  logic [tag_lookup_pkg::TAG_TABLE_IDX_NBITS-1:0] idx,
	output tag_lookup_pkg::tag_entry_t                    entry
);

	logic [tag_lookup_pkg::TAG_TABLE_ENTRIES-1:0] valid_q;
	logic [tag_lookup_pkg::TAG_KEY_NBITS-1:0]     key_q [tag_lookup_pkg::TAG_TABLE_ENTRIES];
	logic [tag_lookup_pkg::RCI_NBITS-1:0]         rci_q [tag_lookup_pkg::TAG_TABLE_ENTRIES];

	// ********************
	// entry storage
	// ********************

	// an unprogrammed entry stays invalid and never matches a key.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (tag_cfg.valid) begin
			valid_q[tag_cfg.idx] <= tag_cfg.entry.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (tag_cfg.valid) begin
			key_q[tag_cfg.idx] <= tag_cfg.entry.key;
			rci_q[tag_cfg.idx] <= tag_cfg.entry.rci;
		end
	end

	// ********************
	// scan read port
	// ********************

	// the sequencer sees the entry at its index in the same cycle.
	always_comb begin
		entry.valid = valid_q[idx];
		entry.key   = key_q[idx];
		entry.rci   = rci_q[idx];
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the tag lookup testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_tag_lookup -o sim_tag_lookup

./obj_dir/sim_tag_lookup > sim.log
cat sim.log

if grep -q "TEST PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- verification/tag_lookup_checker.sv
// ********************
// tag lookup checker
// ********************

module tag_lookup_checker (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  tag_lookup_pkg::lookup_req_t          lookup_req,
	input  logic                                 lookup_ready,
	input  logic [tag_lookup_pkg::NUM_OF_PU-1:0] io_req,
	input  logic [tag_lookup_pkg::NUM_OF_PU-1:0] io_ack,
	input  logic [tag_lookup_pkg::NUM_OF_PU-1:0][tag_lookup_pkg::PU_WIDTH_NBITS-1:0] io_ack_data,
	input  logic                                 exp_ack,
	input  logic [31:0]                          exp_data,
	input  logic [63:0]                          test_name,
	output int                                   checks,
	output int                                   errors
);

	// eight scan cycles, one status cycle, then one more edge to raise ready.
	localparam int BUSY_CYCLES = tag_lookup_pkg::TAG_TABLE_ENTRIES + 2;
	localparam int IO_LATENCY  = 3;

	typedef struct packed {
		logic        ack;
		logic [31:0] data;
		logic [63:0] name;
		logic [31:0] due;
	} pending_t;

	pending_t pend [tag_lookup_pkg::NUM_OF_PU][$];
	pending_t head;
	pending_t item;
	int       cycle;
	int       busy;

	initial begin
		checks = 0;
		errors = 0;
		cycle  = 0;
		busy   = 0;
	end

	task automatic compare(input logic [63:0] name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// ********************
	// sampling on the falling edge
	// ********************

	always @(negedge clk) begin
		if (!rst_n) begin
			for (int p = 0; p < tag_lookup_pkg::NUM_OF_PU; p++) begin
				pend[p].delete();
			end
			busy = 0;
			compare("rst_ack0", 32'h0, 32'(io_ack));
			compare("rst_rdy1", 32'h1, 32'(lookup_ready));
		end else begin
			cycle++;
			// ready stays low for the whole lookup and returns right after it.
			compare("rdy_time", 32'(busy == 0), 32'(lookup_ready));
			if (busy > 0) begin
				busy--;
			end
			if (lookup_req.valid && lookup_ready) begin
				busy = BUSY_CYCLES;
			end

			for (int p = 0; p < tag_lookup_pkg::NUM_OF_PU; p++) begin
				if (pend[p].size() > 0 && pend[p][0].due == 32'(cycle)) begin
					head = pend[p].pop_front();
					compare(head.name, 32'(head.ack), 32'(io_ack[p]));
					if (head.ack) begin
						compare(head.name, head.data, io_ack_data[p]);
					end
				end else if (io_ack[p]) begin
					errors++;
					$display("io_ack on PU %0d arrived with no request due in this cycle", p);
				end
				if (io_req[p]) begin
					item.ack  = exp_ack;
					item.data = exp_data;
					item.name = test_name;
					item.due  = 32'(cycle + IO_LATENCY);
					pend[p].push_back(item);
				end
			end
		end
	end

endmodule

//--- verification/tb_tag_lookup.sv
// ********************
// tag lookup testbench
// ********************

module tb_tag_lookup;

	localparam int PERIOD = 100;
	localparam logic [11:0] KEY_A = 12'h1a5;
	localparam logic [11:0] KEY_B = 12'h2b6;
	localparam logic [11:0] KEY_C = 12'h3c7;

	typedef enum logic [2:0] {
		K_CFG,
		K_LOOKUP,
		K_READ,
		K_WRITE,
		K_IDLE
	} step_kind_t;

	// addr holds the entry index for cfg rows, rci holds the cycle count for idle rows.
	// flag is the entry valid bit, the wait for ready, or the expected ack.
	typedef struct packed {
		step_kind_t  kind;
		logic [1:0]  pid;
		logic [7:0]  addr;
		logic [11:0] key;
		logic [15:0] rci;
		logic        flag;
		logic [31:0] exp_word;
		logic [63:0] name;
	} step_t;

	logic                                 clk;
	logic                                 rst_n;
	tag_lookup_pkg::tag_cfg_t             tag_cfg;
	tag_lookup_pkg::lookup_req_t          lookup_req;
	logic                                 lookup_ready;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] io_req;
	tag_lookup_pkg::io_type [tag_lookup_pkg::NUM_OF_PU-1:0] io_cmd;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0] io_ack;
	logic [tag_lookup_pkg::NUM_OF_PU-1:0][tag_lookup_pkg::PU_WIDTH_NBITS-1:0] io_ack_data;
	logic                                 exp_ack;
	logic [31:0]                          exp_data;
	logic [63:0]                          test_name;
	int                                   checks;
	int                                   errors;
	int                                   seed;
	step_t                                steps [$];

	tag_lookup_top uut (
		.clk          (clk),
		.rst_n        (rst_n),
		.tag_cfg      (tag_cfg),
		.lookup_req   (lookup_req),
		.lookup_ready (lookup_ready),
		.io_req       (io_req),
		.io_cmd       (io_cmd),
		.io_ack       (io_ack),
		.io_ack_data  (io_ack_data)
	);

	tag_lookup_checker u_checker (
		.clk          (clk),
		.rst_n        (rst_n),
		.lookup_req   (lookup_req),
		.lookup_ready (lookup_ready),
		.io_req       (io_req),
		.io_ack       (io_ack),
		.io_ack_data  (io_ack_data),
		.exp_ack      (exp_ack),
		.exp_data     (exp_data),
		.test_name    (test_name),
		.checks       (checks),
		.errors       (errors)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic add_step(input step_kind_t kind, input logic [1:0] pid,
		input logic [7:0] addr, input logic [11:0] key, input logic [15:0] rci,
		input logic flag, input logic [31:0] exp_word, input logic [63:0] name);
		step_t s;
		s = '{kind, pid, addr, key, rci, flag, exp_word, name};
		steps.push_back(s);
	endtask

	// ********************
	// stimulus table
	// ********************

	// a zero key in a lookup row stands for a random key.
	task automatic load_steps();
		add_step(K_LOOKUP, 2'd0, 8'h00, 12'h0,  16'h0,    1'b1, 32'h0,         "unprg_l0");
		add_step(K_LOOKUP, 2'd3, 8'h00, 12'h0,  16'h0,    1'b1, 32'h0,         "unprg_l3");
		add_step(K_READ,   2'd0, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0,         "unprg_p0");
		add_step(K_READ,   2'd3, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0,         "unprg_p3");
		for (int i = 0; i < 7; i++) begin
			add_step(K_CFG, 2'd0, 8'(i), KEY_C, 16'hc000 + 16'(i), 1'b1, 32'h0, "cfg_ovfl");
		end
		add_step(K_LOOKUP, 2'd2, 8'h00, KEY_C,  16'h0,    1'b1, 32'h0,         "lkp_ovf2");
		add_step(K_LOOKUP, 2'd1, 8'h00, KEY_C,  16'h0,    1'b1, 32'h0,         "lkp_ovf1");
		add_step(K_READ,   2'd2, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0000_000e, "ovf_stat");
		add_step(K_READ,   2'd2, 8'h31, 12'h0,  16'h0,    1'b1, 32'hc000_c001, "ovf_wrd1");
		add_step(K_READ,   2'd2, 8'h32, 12'h0,  16'h0,    1'b1, 32'hc002_c003, "ovf_wrd2");
		add_step(K_READ,   2'd2, 8'h33, 12'h0,  16'h0,    1'b1, 32'hc004_c005, "ovf_wrd3");
		add_step(K_CFG,    2'd0, 8'h00, KEY_A,  16'h1111, 1'b1, 32'h0,         "cfg_keys");
		add_step(K_CFG,    2'd0, 8'h01, KEY_B,  16'h2222, 1'b1, 32'h0,         "cfg_keys");
		add_step(K_CFG,    2'd0, 8'h02, KEY_A,  16'h3333, 1'b1, 32'h0,         "cfg_keys");
		add_step(K_CFG,    2'd0, 8'h03, KEY_A,  16'h4444, 1'b1, 32'h0,         "cfg_keys");
		add_step(K_LOOKUP, 2'd1, 8'h00, KEY_A,  16'h0,    1'b1, 32'h0,         "lkp_tagA");
		add_step(K_READ,   2'd1, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0000_0003, "a_status");
		add_step(K_READ,   2'd1, 8'h31, 12'h0,  16'h0,    1'b1, 32'h1111_3333, "a_word_1");
		// the low half of word 2 still holds the fourth result of the overflow run.
		add_step(K_READ,   2'd1, 8'h32, 12'h0,  16'h0,    1'b1, 32'h4444_c003, "a_word_2");
		add_step(K_READ,   2'd0, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0,         "p0_clean");
		add_step(K_READ,   2'd1, 8'h51, 12'h0,  16'h0,    1'b0, 32'h0,         "oth_regn");
		add_step(K_WRITE,  2'd1, 8'h31, 12'h0,  16'h0,    1'b1, 32'h0,         "wr_zero0");
		add_step(K_READ,   2'd1, 8'h31, 12'h0,  16'h0,    1'b1, 32'h1111_3333, "wr_noeff");
		add_step(K_READ,   2'd0, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0,         "b2b_p0_0");
		add_step(K_READ,   2'd1, 8'h31, 12'h0,  16'h0,    1'b1, 32'h1111_3333, "b2b_p1_1");
		add_step(K_READ,   2'd2, 8'h33, 12'h0,  16'h0,    1'b1, 32'hc004_c005, "b2b_p2_3");
		add_step(K_READ,   2'd3, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0,         "b2b_p3_0");
		add_step(K_READ,   2'd2, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0000_000e, "b2b_p2_0");
		add_step(K_READ,   2'd2, 8'h31, 12'h0,  16'h0,    1'b1, 32'hc000_c001, "b2b_p2_1");
		add_step(K_READ,   2'd1, 8'h32, 12'h0,  16'h0,    1'b1, 32'h4444_c003, "b2b_p1_2");
		// the second strobe lands while the first lookup is still busy.
		add_step(K_LOOKUP, 2'd0, 8'h00, KEY_B,  16'h0,    1'b0, 32'h0,         "drop_fst");
		add_step(K_LOOKUP, 2'd3, 8'h00, KEY_A,  16'h0,    1'b1, 32'h0,         "drop_sec");
		add_step(K_READ,   2'd0, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0000_0001, "drop_acc");
		add_step(K_READ,   2'd3, 8'h30, 12'h0,  16'h0,    1'b1, 32'h0,         "drop_ign");
		add_step(K_IDLE,   2'd0, 8'h00, 12'h0,  16'd6,    1'b0, 32'h0,         "drain_io");
	endtask

	// each step starts just after a rising edge and ends on one.
	task automatic apply_step(input step_t s);
		logic [11:0] key_val;
		tag_cfg.valid    <= 1'b0;
		lookup_req.valid <= 1'b0;
		io_req           <= '0;
		exp_ack          <= 1'b0;
		case (s.kind)
			K_CFG: begin
				tag_cfg <= {1'b1, s.addr[2:0], s.flag, s.key, s.rci};
			end
			K_LOOKUP: begin
				key_val = (s.key == 12'h0) ? 12'($random(seed)) : s.key;
				lookup_req <= {1'b1, s.pid, key_val};
				if (s.flag) begin
					@(posedge clk);
					lookup_req.valid <= 1'b0;
					do begin
						@(negedge clk);
					end while (!lookup_ready);
				end
			end
			K_READ, K_WRITE: begin
				io_req          <= 4'b0001 << s.pid;
				io_cmd[s.pid]   <= {s.kind == K_WRITE, s.addr, 32'hdead_beef};
				exp_ack         <= s.flag;
				exp_data        <= s.exp_word;
				test_name       <= s.name;
			end
			default: begin
				repeat (s.rci) @(posedge clk);
			end
		endcase
		@(posedge clk);
	endtask

	initial begin
		seed       = 32'h82bfeb97;
		rst_n      = 1'b0;
		tag_cfg    = '0;
		lookup_req = '0;
		io_req     = '0;
		io_cmd     = '0;
		exp_ack    = 1'b0;
		exp_data   = '0;
		test_name  = '0;
		load_steps();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < steps.size(); i++) begin
			apply_step(steps[i]);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// ********************
	// watchdog
	// ********************

	initial begin
		int limit;
		#1;
		limit = steps.size() * 20 + 4;
		#(limit * PERIOD);
		$display("timeout: the stimulus table did not finish within %0d cycles", limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule
